/* hdl/axi2per_pkg.sv */
`default_nettype none

package axi2per_pkg;

  // **************************************************
  // Widths
  // **************************************************

  // AXI slave port
  localparam int unsigned AxiAddrWidth = 32;
  localparam int unsigned AxiDataWidth = 64;
  localparam int unsigned AxiIdWidth   = 3;

  // Peripheral interconnect master port
  localparam int unsigned PerDataWidth = 32;
  localparam int unsigned PerIdWidth   = 5;

  // **************************************************
  // Vector types
  // **************************************************

  // Byte address, shared by both ports
  typedef logic [AxiAddrWidth-1:0]   axi_addr_t;
  typedef logic [AxiDataWidth-1:0]   axi_data_t;
  // One strobe bit per data byte
  typedef logic [AxiDataWidth/8-1:0] axi_strb_t;
  typedef logic [AxiIdWidth-1:0]     axi_id_t;
  typedef logic [PerDataWidth-1:0]   per_data_t;
  typedef logic [PerDataWidth/8-1:0] per_be_t;
  // Peripheral ID holds the AXI ID zero-extended
  typedef logic [PerIdWidth-1:0]     per_id_t;
  typedef logic [1:0]                axi_resp_t;

  // AXI response codes in use
  localparam axi_resp_t RespOkay   = 2'b00;
  localparam axi_resp_t RespSlvErr = 2'b10;

  // **************************************************
  // AXI channel payloads
  // **************************************************

  // AR and AW share one layout
  typedef struct packed {
    axi_addr_t addr;
    axi_id_t   id;
  } axi_ax_t;

  typedef struct packed {
    axi_data_t data;
    axi_strb_t strb;
  } axi_w_t;

  typedef struct packed {
    axi_data_t data;
    axi_id_t   id;
    axi_resp_t resp;
    logic      last;
  } axi_r_t;

  typedef struct packed {
    axi_id_t   id;
    axi_resp_t resp;
  } axi_b_t;

  // **************************************************
  // Peripheral port payloads
  // **************************************************

  // wen is high for a read
  typedef struct packed {
    axi_addr_t add;
    logic      wen;
    per_data_t wdata;
    per_be_t   be;
    per_id_t   id;
  } per_req_t;

  // opc high flags an error
  typedef struct packed {
    logic      opc;
    per_data_t rdata;
  } per_resp_t;

  // Handed from the request side to the response side at the grant
  typedef struct packed {
    logic    wen;
    axi_id_t id;
    logic    hi_word;
  } trans_info_t;

endpackage

`default_nettype wire

/* hdl/axi2per_req_channel.sv */
`default_nettype none

module axi2per_req_channel (
  input  logic                       clk_i,
  input  logic                       rst_ni,

  // AXI read address
  input  logic                       ar_valid_i,
  input  axi2per_pkg::axi_ax_t       ar_i,
  output logic                       ar_ready_o,

  // AXI write address
  input  logic                       aw_valid_i,
  input  axi2per_pkg::axi_ax_t       aw_i,
  output logic                       aw_ready_o,

  // AXI write data
  input  logic                       w_valid_i,
  input  axi2per_pkg::axi_w_t        w_i,
  output logic                       w_ready_o,

  // Peripheral request
  output logic                       per_req_o,
  output axi2per_pkg::per_req_t      per_req_data_o,
  input  logic                       per_gnt_i,

  // Link to the response channel
  output logic                       trans_req_o,
  output axi2per_pkg::trans_info_t   trans_info_o,
  input  logic                       trans_done_i
);

  import axi2per_pkg::*;

  typedef enum logic [1:0] {
    ReqIdle,
    ReqRequest,
    ReqWaitResp
  } req_state_e;

  req_state_e state_d, state_q;

  // Registered peripheral request
  per_req_t   req_d, req_q;

  logic       ar_accept;
  logic       wr_accept;
  logic       hi_word;

  // **************************************************
  // Acceptance
  // **************************************************

  // Reads win over a complete write
  assign ar_accept = (state_q == ReqIdle) && ar_valid_i;
  // Write needs address and data together
  assign wr_accept = (state_q == ReqIdle) && !ar_valid_i && aw_valid_i && w_valid_i;

  // One cycle ready pulses in idle
  assign ar_ready_o = ar_accept;
  assign aw_ready_o = wr_accept;
  assign w_ready_o  = wr_accept;

  // Address bit 2 picks the 32-bit half of the AXI data
  assign hi_word = aw_i.addr[2];

  // Next request payload
  always_comb begin
    req_d = req_q;
    if (ar_accept) begin
      req_d.add   = ar_i.addr;
      req_d.wen   = 1'b1;
      req_d.wdata = '0;
      // Full word on reads
      req_d.be    = '1;
      req_d.id    = {{(PerIdWidth-AxiIdWidth){1'b0}}, ar_i.id};
    end else if (wr_accept) begin
      req_d.add = aw_i.addr;
      req_d.wen = 1'b0;
      if (hi_word) begin
        req_d.wdata = w_i.data[AxiDataWidth-1:PerDataWidth];
        req_d.be    = w_i.strb[AxiDataWidth/8-1:PerDataWidth/8];
      end else begin
        req_d.wdata = w_i.data[PerDataWidth-1:0];
        req_d.be    = w_i.strb[PerDataWidth/8-1:0];
      end
      req_d.id = {{(PerIdWidth-AxiIdWidth){1'b0}}, aw_i.id};
    end
  end

  // Payload register without reset
  always_ff @(posedge clk_i) begin
    if (ar_accept || wr_accept) begin
      req_q <= req_d;
    end
  end

  // **************************************************
  // State machine
  // **************************************************

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      ReqIdle: begin
        if (ar_accept || wr_accept) begin
          state_d = ReqRequest;
        end
      end
      // Hold the request until granted
      ReqRequest: begin
        if (per_gnt_i) begin
          state_d = ReqWaitResp;
        end
      end
      // Only one transaction in flight
      ReqWaitResp: begin
        if (trans_done_i) begin
          state_d = ReqIdle;
        end
      end
      default: state_d = ReqIdle;
    endcase
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ReqIdle;
    end else begin
      state_q <= state_d;
    end
  end

  // **************************************************
  // Outputs
  // **************************************************

  // Request level while waiting for the grant
  assign per_req_o      = (state_q == ReqRequest);
  assign per_req_data_o = req_q;

  // Grant cycle hands over direction, ID and alignment
  assign trans_req_o          = per_req_o && per_gnt_i;
  assign trans_info_o.wen     = req_q.wen;
  assign trans_info_o.id      = req_q.id[AxiIdWidth-1:0];
  assign trans_info_o.hi_word = req_q.add[2];

endmodule

`default_nettype wire

/* hdl/axi2per_res_channel.sv */
`default_nettype none

module axi2per_res_channel (
  input  logic                       clk_i,
  input  logic                       rst_ni,

  // Peripheral response
  input  logic                       per_r_valid_i,
  input  axi2per_pkg::per_resp_t     per_resp_i,

  // Link from the request channel
  input  logic                       trans_req_i,
  input  axi2per_pkg::trans_info_t   trans_info_i,
  output logic                       trans_done_o,

  // AXI read data
  output logic                       r_valid_o,
  output axi2per_pkg::axi_r_t        r_o,
  input  logic                       r_ready_i,

  // AXI write response
  output logic                       b_valid_o,
  output axi2per_pkg::axi_b_t        b_o,
  input  logic                       b_ready_i
);

  import axi2per_pkg::*;

  typedef enum logic {
    ResIdle,
    ResPending
  } res_state_e;

  res_state_e  state_d, state_q;

  // Buffered transaction info and peripheral response
  trans_info_t info_q;
  per_resp_t   resp_q;

  logic        pending;
  logic        handshake;
  axi_resp_t   resp_code;

  // **************************************************
  // Buffers
  // **************************************************

  // Info arrives at the grant
  always_ff @(posedge clk_i) begin
    if (trans_req_i) begin
      info_q <= trans_info_i;
    end
  end

  // Response word and error flag on the pulse
  always_ff @(posedge clk_i) begin
    if (per_r_valid_i) begin
      resp_q <= per_resp_i;
    end
  end

  // **************************************************
  // State machine
  // **************************************************

  assign pending = (state_q == ResPending);

  // Ready of the channel that is presented
  assign handshake = info_q.wen ? r_ready_i : b_ready_i;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      ResIdle: begin
        if (per_r_valid_i) begin
          state_d = ResPending;
        end
      end
      // Held through back-pressure
      ResPending: begin
        if (handshake) begin
          state_d = ResIdle;
        end
      end
      default: state_d = ResIdle;
    endcase
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ResIdle;
    end else begin
      state_q <= state_d;
    end
  end

  // **************************************************
  // AXI outputs
  // **************************************************

  // Read uses R, write uses B
  assign r_valid_o    = pending && info_q.wen;
  assign b_valid_o    = pending && !info_q.wen;
  assign trans_done_o = pending && handshake;

  // Peripheral error becomes SLVERR
  assign resp_code = resp_q.opc ? RespSlvErr : RespOkay;

  // Word placed in the half picked by address bit 2
  always_comb begin
    if (info_q.hi_word) begin
      r_o.data = {resp_q.rdata, {PerDataWidth{1'b0}}};
    end else begin
      r_o.data = {{PerDataWidth{1'b0}}, resp_q.rdata};
    end
    r_o.id   = info_q.id;
    r_o.resp = resp_code;
    // Single beat only
    r_o.last = 1'b1;
  end

  assign b_o.id   = info_q.id;
  assign b_o.resp = resp_code;

endmodule

`default_nettype wire

/* hdl/axi2per_bridge.sv */
`default_nettype none

module axi2per_bridge (
  input  logic                       clk_i,
  input  logic                       rst_ni,

  // AXI read address
  input  logic                       ar_valid_i,
  input  axi2per_pkg::axi_ax_t       ar_i,
  output logic                       ar_ready_o,

  // AXI write address
  input  logic                       aw_valid_i,
  input  axi2per_pkg::axi_ax_t       aw_i,
  output logic                       aw_ready_o,

  // AXI write data
  input  logic                       w_valid_i,
  input  axi2per_pkg::axi_w_t        w_i,
  output logic                       w_ready_o,

  // AXI read data
  output logic                       r_valid_o,
  output axi2per_pkg::axi_r_t        r_o,
  input  logic                       r_ready_i,

  // AXI write response
  output logic                       b_valid_o,
  output axi2per_pkg::axi_b_t        b_o,
  input  logic                       b_ready_i,

  // Peripheral master port
  output logic                       per_req_o,
  output axi2per_pkg::per_req_t      per_req_data_o,
  input  logic                       per_gnt_i,
  input  logic                       per_r_valid_i,
  input  axi2per_pkg::per_resp_t     per_resp_i
);

  import axi2per_pkg::*;

  // Request to response side handover
  logic        trans_req;
  trans_info_t trans_info;
  logic        trans_done;

  // Address and write data into one peripheral request
  axi2per_req_channel i_req_channel (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .ar_valid_i     (ar_valid_i),
    .ar_i           (ar_i),
    .ar_ready_o     (ar_ready_o),
    .aw_valid_i     (aw_valid_i),
    .aw_i           (aw_i),
    .aw_ready_o     (aw_ready_o),
    .w_valid_i      (w_valid_i),
    .w_i            (w_i),
    .w_ready_o      (w_ready_o),
    .per_req_o      (per_req_o),
    .per_req_data_o (per_req_data_o),
    .per_gnt_i      (per_gnt_i),
    .trans_req_o    (trans_req),
    .trans_info_o   (trans_info),
    .trans_done_i   (trans_done)
  );

  // Peripheral response back to R or B
  axi2per_res_channel i_res_channel (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .per_r_valid_i (per_r_valid_i),
    .per_resp_i    (per_resp_i),
    .trans_req_i   (trans_req),
    .trans_info_i  (trans_info),
    .trans_done_o  (trans_done),
    .r_valid_o     (r_valid_o),
    .r_o           (r_o),
    .r_ready_i     (r_ready_i),
    .b_valid_o     (b_valid_o),
    .b_o           (b_o),
    .b_ready_i     (b_ready_i)
  );

endmodule

`default_nettype wire

/* verif/tb_axi2per.sv */
`default_nettype none

module tb_axi2per;

  timeunit 1ns;
  timeprecision 1ps;

  import axi2per_pkg::*;

  // **************************************************
  // Run setup
  // **************************************************

  localparam int unsigned NumTrans       = 400;
  localparam int unsigned CyclesPerTrans = 20;
  localparam int unsigned ResetCycles    = 16;
  localparam int unsigned CycleLimit     = NumTrans * CyclesPerTrans + ResetCycles;
  localparam logic [31:0] Seed           = 32'h9ba9;
  // Bit 8 splits the 64-word window into an OKAY half and a SLVERR half
  localparam axi_addr_t   WindowBase     = 32'h0000_0080;

  logic        clk_i;
  logic        rst_ni;
  logic        ar_valid_i, ar_ready_o;
  axi_ax_t     ar_i;
  logic        aw_valid_i, aw_ready_o;
  axi_ax_t     aw_i;
  logic        w_valid_i, w_ready_o;
  axi_w_t      w_i;
  logic        r_valid_o, r_ready_i;
  axi_r_t      r_o;
  logic        b_valid_o, b_ready_i;
  axi_b_t      b_o;
  logic        per_req_o, per_gnt_i, per_r_valid_i;
  per_req_t    per_req_data_o;
  per_resp_t   per_resp_i;

  // Separate random streams for stimulus and responder
  logic [31:0] stim_rng;
  logic [31:0] per_rng;

  // Reference memory and responder memory
  per_data_t   model_mem [64];
  per_data_t   per_mem [64];

  // Expected peripheral request of the open transaction
  axi_addr_t   exp_add;
  logic        exp_wen;
  per_data_t   exp_wdata;
  per_be_t     exp_be;
  per_id_t     exp_id;

  int unsigned cycle_count;

  axi2per_bridge UUT (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .ar_valid_i     (ar_valid_i),
    .ar_i           (ar_i),
    .ar_ready_o     (ar_ready_o),
    .aw_valid_i     (aw_valid_i),
    .aw_i           (aw_i),
    .aw_ready_o     (aw_ready_o),
    .w_valid_i      (w_valid_i),
    .w_i            (w_i),
    .w_ready_o      (w_ready_o),
    .r_valid_o      (r_valid_o),
    .r_o            (r_o),
    .r_ready_i      (r_ready_i),
    .b_valid_o      (b_valid_o),
    .b_o            (b_o),
    .b_ready_i      (b_ready_i),
    .per_req_o      (per_req_o),
    .per_req_data_o (per_req_data_o),
    .per_gnt_i      (per_gnt_i),
    .per_r_valid_i  (per_r_valid_i),
    .per_resp_i     (per_resp_i)
  );

  // 8 ns clock
  initial clk_i = 1'b0;
  always #4 clk_i = ~clk_i;

  // **************************************************
  // Helpers
  // **************************************************

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // Start contents depend on every address bit
  function automatic per_data_t fill_word(input axi_addr_t a);
    return (a * 32'h9e37_79b1) ^ 32'h5a5a_5a5a;
  endfunction

  function automatic logic [5:0] word_index(input axi_addr_t a);
    axi_addr_t off;
    off = a - WindowBase;
    return off[7:2];
  endfunction

  // Byte lanes not enabled keep the old value
  function automatic per_data_t merge_bytes(input per_data_t old_word,
                                            input per_data_t new_word,
                                            input per_be_t   be);
    per_data_t w;
    w = old_word;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        w[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return w;
  endfunction

  task automatic check_eq(input logic [127:0] actual, input logic [127:0] expected,
                          input string what);
    if (actual !== expected) begin
      $display("Mismatch at %0t ns: %s (got %0h, expected %0h)", $time, what, actual, expected);
      $display("** FAIL **");
      $fatal(1, "check failed");
    end
  endtask

  // Hang guard
  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count > CycleLimit) begin
      $display("Timeout: the run took more than %0d cycles", CycleLimit);
      $display("** FAIL **");
      $fatal(1, "timeout");
    end
  end

  // **************************************************
  // AXI master side
  // **************************************************

  // AW and W keep any earlier valid so that read priority is exercised
  task automatic issue_read(input axi_addr_t addr, input axi_id_t id);
    @(negedge clk_i);
    ar_valid_i = 1'b1;
    ar_i.addr  = addr;
    ar_i.id    = id;
    @(posedge clk_i);
    while (!ar_ready_o) begin
      @(posedge clk_i);
    end
    check_eq(128'({aw_ready_o, w_ready_o}), '0, "write ready during a read handshake");
    @(negedge clk_i);
    ar_valid_i = 1'b0;
  endtask

  // AW and W presented together
  task automatic issue_write(input axi_addr_t addr, input axi_id_t id,
                             input axi_data_t data, input axi_strb_t strb);
    @(negedge clk_i);
    ar_valid_i = 1'b0;
    aw_valid_i = 1'b1;
    aw_i.addr  = addr;
    aw_i.id    = id;
    w_valid_i  = 1'b1;
    w_i.data   = data;
    w_i.strb   = strb;
    @(posedge clk_i);
    while (!aw_ready_o) begin
      @(posedge clk_i);
    end
    check_eq(128'(w_ready_o), 128'(1), "W ready apart from AW ready");
    @(negedge clk_i);
    aw_valid_i = 1'b0;
    w_valid_i  = 1'b0;
  endtask

  // Runs from a falling edge until the R or B handshake
  task automatic wait_response(input logic is_read, input axi_r_t exp_r, input axi_b_t exp_b);
    logic seen;
    logic done;
    seen = 1'b0;
    done = 1'b0;
    // Early address presented while busy is not taken
    stim_rng   = xorshift32(stim_rng);
    ar_valid_i = stim_rng[0];
    aw_valid_i = stim_rng[0];
    w_valid_i  = stim_rng[0];
    while (!done) begin
      // About 70% ready
      stim_rng  = xorshift32(stim_rng);
      r_ready_i = (stim_rng % 10) < 7;
      stim_rng  = xorshift32(stim_rng);
      b_ready_i = (stim_rng % 10) < 7;
      @(posedge clk_i);
      check_eq(128'({ar_ready_o, aw_ready_o, w_ready_o}), '0, "address accepted while busy");
      check_eq(128'(r_valid_o && b_valid_o), '0, "R and B valid together");
      if (is_read) begin
        check_eq(128'(b_valid_o), '0, "B valid on a read");
        if (seen) begin
          check_eq(128'(r_valid_o), 128'(1), "R valid dropped before handshake");
        end
        // Payload checked on every valid cycle also proves it stable
        if (r_valid_o) begin
          check_eq(128'(r_o), 128'(exp_r), "R payload");
          seen = 1'b1;
          done = r_ready_i;
        end
      end else begin
        check_eq(128'(r_valid_o), '0, "R valid on a write");
        if (seen) begin
          check_eq(128'(b_valid_o), 128'(1), "B valid dropped before handshake");
        end
        if (b_valid_o) begin
          check_eq(128'(b_o), 128'(exp_b), "B payload");
          seen = 1'b1;
          done = b_ready_i;
        end
      end
      if (!done) begin
        @(negedge clk_i);
      end
    end
  endtask

  initial begin : stimulus
    axi_addr_t   addr;
    axi_id_t     id;
    axi_data_t   data;
    axi_strb_t   strb;
    axi_resp_t   resp;
    logic        is_read;
    logic        hi;
    per_data_t   word;
    axi_r_t      exp_r;
    axi_b_t      exp_b;
    int unsigned n_reads;
    int unsigned n_writes;
    stim_rng    = Seed;
    cycle_count = 0;
    n_reads     = 0;
    n_writes    = 0;
    rst_ni      = 1'b0;
    ar_valid_i  = 1'b0;
    ar_i        = '0;
    aw_valid_i  = 1'b0;
    aw_i        = '0;
    w_valid_i   = 1'b0;
    w_i         = '0;
    r_ready_i   = 1'b0;
    b_ready_i   = 1'b0;
    for (int i = 0; i < 64; i++) begin
      model_mem[i] = fill_word(WindowBase + 32'(i * 4));
    end
    // Reset state of all handshake outputs
    repeat (ResetCycles) begin
      @(negedge clk_i);
      check_eq(128'({ar_ready_o, aw_ready_o, w_ready_o}), '0, "ready high in reset");
      check_eq(128'({r_valid_o, b_valid_o, per_req_o}), '0, "valid or request high in reset");
    end
    rst_ni = 1'b1;

    for (int n = 0; n < NumTrans; n++) begin
      stim_rng = xorshift32(stim_rng);
      is_read  = stim_rng[0];
      addr     = WindowBase + 32'({stim_rng[6:1], 2'b00});
      id       = stim_rng[9:7];
      strb     = stim_rng[17:10];
      stim_rng = xorshift32(stim_rng);
      data[31:0]  = stim_rng;
      stim_rng = xorshift32(stim_rng);
      data[63:32] = stim_rng;
      hi   = addr[2];
      resp = addr[8] ? RespSlvErr : RespOkay;
      // Expected peripheral request
      exp_add = addr;
      exp_wen = is_read;
      exp_id  = {2'b00, id};
      if (is_read) begin
        word       = model_mem[word_index(addr)];
        exp_r.data = hi ? {word, 32'h0} : {32'h0, word};
        exp_r.id   = id;
        exp_r.resp = resp;
        exp_r.last = 1'b1;
        issue_read(addr, id);
        n_reads++;
      end else begin
        exp_wdata = hi ? data[63:32] : data[31:0];
        exp_be    = hi ? strb[7:4] : strb[3:0];
        model_mem[word_index(addr)] = merge_bytes(model_mem[word_index(addr)], exp_wdata, exp_be);
        exp_b.id   = id;
        exp_b.resp = resp;
        issue_write(addr, id, data, strb);
        n_writes++;
      end
      wait_response(is_read, exp_r, exp_b);
    end

    @(negedge clk_i);
    ar_valid_i = 1'b0;
    aw_valid_i = 1'b0;
    w_valid_i  = 1'b0;
    $display("Completed %0d reads and %0d writes", n_reads, n_writes);
    $display("** PASS **");
    $finish;
  end

  // **************************************************
  // Peripheral responder
  // **************************************************

  initial begin : responder
    per_req_t    req;
    int unsigned delay;
    per_rng       = ~Seed;
    per_gnt_i     = 1'b0;
    per_r_valid_i = 1'b0;
    per_resp_i    = '0;
    for (int i = 0; i < 64; i++) begin
      per_mem[i] = fill_word(WindowBase + 32'(i * 4));
    end
    forever begin
      @(negedge clk_i);
      if (per_req_o) begin
        // Request holds through a grant delay of 0 to 3 cycles
        per_rng = xorshift32(per_rng);
        delay   = per_rng % 4;
        repeat (delay) begin
          @(negedge clk_i);
          check_eq(128'(per_req_o), 128'(1), "request dropped before grant");
        end
        req       = per_req_data_o;
        per_gnt_i = 1'b1;
        @(negedge clk_i);
        per_gnt_i = 1'b0;
        check_eq(128'(req.add), 128'(exp_add), "peripheral address");
        check_eq(128'(req.wen), 128'(exp_wen), "peripheral direction");
        check_eq(128'(req.id), 128'(exp_id), "peripheral ID");
        per_rng = xorshift32(per_rng);
        if (req.wen) begin
          per_resp_i.rdata = per_mem[word_index(req.add)];
        end else begin
          check_eq(128'(req.wdata), 128'(exp_wdata), "peripheral write data half");
          check_eq(128'(req.be), 128'(exp_be), "peripheral byte enables");
          per_mem[word_index(req.add)] = merge_bytes(per_mem[word_index(req.add)],
                                                     req.wdata, req.be);
          // B carries no data so write responses return junk
          per_resp_i.rdata = per_rng;
        end
        // Bit 8 of the address flags an error
        per_resp_i.opc = req.add[8];
        // Response 1 to 3 cycles after the grant
        delay = 1 + per_rng % 3;
        repeat (delay - 1) begin
          @(negedge clk_i);
        end
        per_r_valid_i = 1'b1;
        @(negedge clk_i);
        per_r_valid_i = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* files.f */
hdl/axi2per_pkg.sv
hdl/axi2per_req_channel.sv
hdl/axi2per_res_channel.sv
hdl/axi2per_bridge.sv
verif/tb_axi2per.sv

/* run_sim.sh */
#!/bin/sh
# Compile the bridge and its testbench with Verilator, then run it.
# A failing check ends the simulation with a nonzero exit status.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
  -f files.f \
  --top-module tb_axi2per \
  -Mdir obj_dir \
  -o tb_axi2per

./obj_dir/tb_axi2per
